// File: rtl/execDecode.sv
/*
 * Command classifier
 * One request per valid command towards ALU, move path or a load/store unit
 * Counts commands that match no path
 */
`timescale 1ns/10ps
`default_nettype none

module execDecode
	import execPkg::*;
(
	input  wire              clock,
	input  wire              reset,
	input  wire command_t    command,
	output logic             aluReq,
	output logic             moveReq,
	output logic [1:0]       lsuReq
);

	localparam int DROP_W = 16;

	logic              isAluType;
	logic              isMemType;
	logic              isMove;
	logic              moveCodeOk;
	logic              dropped;
	logic [DROP_W-1:0] droppedCount;   // Commands that matched no path

	//////////////////////////////////////////////////
	// Classification
	//////////////////////////////////////////////////

	assign isAluType = command.valid && (command.opType == ALU);
	assign isMemType = command.valid && (command.opType == MEM);

	// Class 3 under ALU is a register move
	assign isMove     = isAluType && (command.opClass == MOVE_CLASS);
	assign moveCodeOk = (command.opCode == MOVE_PLAIN) ||
	                    (command.opCode == MOVE_PRED);

	assign aluReq  = isAluType && !isMove;
	assign moveReq = isMove && moveCodeOk;

	// Low class bit picks the unit
	assign lsuReq[0] = isMemType && !command.opClass[0];   // Even unit
	assign lsuReq[1] = isMemType &&  command.opClass[0];   // Odd unit

	// Reserved types and unknown move codes
	assign dropped = command.valid && !(aluReq || moveReq || isMemType);

	//////////////////////////////////////////////////
	// Dropped-command counter
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			droppedCount <= '0;
		end else if (dropped) begin
			droppedCount <= droppedCount + 1'b1;   // Wraps
		end
	end

endmodule

`default_nettype wire

// File: rtl/execPkg.sv
/*
 * Shared types of the scalar execution stage
 * Widths, opcode enums, command and write-back token structs,
 * memory request struct and the load/store FSM states
 */
`default_nettype none

package execPkg;

	localparam int DATA_W    = 32;
	localparam int REG_IDX_W = 5;
	localparam int ISSUE_W   = 8;

	typedef logic [DATA_W-1:0]    data_t;       // Operand and result word
	typedef logic [REG_IDX_W-1:0] regIdx_t;     // Register index
	typedef logic [ISSUE_W-1:0]   issueNo_t;    // Tag carried to write-back
	typedef logic [1:0]           opClass_t;

	typedef enum logic [1:0] {
		ALU   = 2'b00,
		RSVD1 = 2'b01,
		RSVD2 = 2'b10,
		MEM   = 2'b11
	} opType_e;

	typedef enum logic [2:0] {
		ADD   = 3'd0,
		SUB   = 3'd1,
		AND   = 3'd2,
		OR    = 3'd3,
		XOR   = 3'd4,
		SLL   = 3'd5,
		SRL   = 3'd6,
		CMPLT = 3'd7      // Signed compare into a predicate
	} aluOp_e;

	// Register move encoding under the ALU type
	localparam opClass_t   MOVE_CLASS = 2'd3;
	localparam logic [2:0] MOVE_PLAIN = 3'd1;
	localparam logic [2:0] MOVE_PRED  = 3'd2;

	typedef struct packed {
		logic       valid;
		opType_e    opType;
		opClass_t   opClass;
		logic [2:0] opCode;   // aluOp_e for ALU classes 0 to 2
		regIdx_t    dst;
		regIdx_t    src1;
		issueNo_t   issueNo;
		data_t      data1;
		data_t      data2;
		data_t      data3;    // Store value
	} command_t;

	typedef struct packed {
		logic     valid;
		regIdx_t  dst;
		issueNo_t issueNo;
	} wbToken_t;

	typedef struct packed {
		logic  valid;
		logic  write;
		data_t address;
		data_t writeData;
	} memReq_t;

	typedef enum logic [1:0] {
		IDLE    = 2'd0,
		REQUEST = 2'd1,
		ACCESS  = 2'd2,
		DONE    = 2'd3
	} lsuState_e;

endpackage

`default_nettype wire

// File: rtl/loadStoreUnit.sv
/*
 * Load/store unit
 * Command capture, address adder, request/grant/end-of-access FSM,
 * write-back token and load/store stall levels
 */
`timescale 1ns/10ps
`default_nettype none

module loadStoreUnit
	import execPkg::*;
(
	input  wire              clock,
	input  wire              reset,
	input  wire              lsuReq,
	input  wire command_t    command,
	input  wire              memReady,
	input  wire              memGrant,
	input  wire              endAccess,
	input  wire data_t       loadData,
	output memReq_t          memReq,
	output wbToken_t         wbToken,
	output data_t            wbData,
	output logic             done,
	output logic             loadStall,
	output logic             storeStall
);

	lsuState_e state;
	lsuState_e nextState;
	logic      capWrite;        // Captured access
	data_t     capAddress;
	data_t     capWriteData;
	regIdx_t   capDst;
	issueNo_t  capIssueNo;
	logic      busy;
	logic      reqValid;

	//////////////////////////////////////////////////
	// State machine
	//////////////////////////////////////////////////

	always_comb begin
		nextState = state;
		case (state)
			IDLE: begin
				if (lsuReq) begin
					nextState = REQUEST;
				end
			end
			REQUEST: begin
				if (reqValid && memGrant) begin
					nextState = ACCESS;
				end
			end
			ACCESS: begin
				if (endAccess) begin
					nextState = DONE;
				end
			end
			DONE: begin
				nextState = IDLE;   // Single done cycle
			end
			default: begin
				nextState = IDLE;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= IDLE;
		end else begin
			state <= nextState;
		end
	end

	//////////////////////////////////////////////////
	// Command capture
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if ((state == IDLE) && lsuReq) begin
			capWrite     <= command.opClass[1];             // Store direction
			capAddress   <= command.data1 + command.data2;
			capWriteData <= command.data3;
			capDst       <= command.dst;
			capIssueNo   <= command.issueNo;
		end
	end

	// Loaded word lands with end of access
	always_ff @(posedge clock) begin
		if ((state == ACCESS) && endAccess) begin
			wbData <= capWrite ? '0 : loadData;
		end
	end

	//////////////////////////////////////////////////
	// Outputs
	//////////////////////////////////////////////////

	// Request only while the port is ready
	assign reqValid = (state == REQUEST) && memReady;

	assign memReq = '{
		valid:     reqValid,
		write:     capWrite,
		address:   capAddress,
		writeData: capWriteData
	};

	assign wbToken = '{valid: (state == DONE), dst: capDst, issueNo: capIssueNo};
	assign done    = wbToken.valid;

	assign busy       = (state != IDLE);
	assign loadStall  = busy && !capWrite;
	assign storeStall = busy &&  capWrite;

endmodule

`default_nettype wire

// File: rtl/scalarAlu.sv
/*
 * Two-stage scalar ALU with predicate registers
 * One-cycle register move path, plain or from a predicate
 */
`timescale 1ns/10ps
`default_nettype none

module scalarAlu
	import execPkg::*;
#(
	parameter int PRED_COUNT = 2
)(
	input  wire              clock,
	input  wire              reset,
	input  wire              stall,
	input  wire              aluReq,
	input  wire              moveReq,
	input  wire command_t    command,
	output wbToken_t         aluToken,
	output data_t            aluData,
	output logic             aluDone,
	output wbToken_t         moveToken,
	output data_t            moveData,
	output logic             moveDone
);

	localparam int PRED_IDX_W = (PRED_COUNT > 1) ? $clog2(PRED_COUNT) : 1;

	typedef struct packed {
		aluOp_e   op;
		regIdx_t  dst;
		issueNo_t issueNo;
		data_t    data1;
		data_t    data2;
	} aluStage_t;

	logic                  s1Valid;
	aluStage_t             s1;
	data_t                 result;
	logic                  lessThan;
	logic [PRED_COUNT-1:0] predReg;
	logic                  predBit;

	//////////////////////////////////////////////////
	// Stage one, operand capture
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			s1Valid <= 1'b0;
		end else if (!stall) begin
			s1Valid <= aluReq;
		end
	end

	always_ff @(posedge clock) begin
		if (!stall) begin
			s1.op      <= aluOp_e'(command.opCode);
			s1.dst     <= command.dst;
			s1.issueNo <= command.issueNo;
			s1.data1   <= command.data1;
			s1.data2   <= command.data2;
		end
	end

	//////////////////////////////////////////////////
	// Stage two, compute and write-back
	//////////////////////////////////////////////////

	assign lessThan = $signed(s1.data1) < $signed(s1.data2);

	always_comb begin
		case (s1.op)
			ADD:     result = s1.data1 + s1.data2;
			SUB:     result = s1.data1 - s1.data2;
			AND:     result = s1.data1 & s1.data2;
			OR:      result = s1.data1 | s1.data2;
			XOR:     result = s1.data1 ^ s1.data2;
			SLL:     result = s1.data1 << s1.data2[4:0];
			SRL:     result = s1.data1 >> s1.data2[4:0];
			CMPLT:   result = {{(DATA_W-1){1'b0}}, lessThan};
			default: result = '0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			aluToken <= '0;
			predReg  <= '0;
		end else if (!stall) begin
			aluToken <= '{valid: s1Valid, dst: s1.dst, issueNo: s1.issueNo};
			if (s1Valid && (s1.op == CMPLT)) begin
				predReg[s1.dst[PRED_IDX_W-1:0]] <= lessThan;   // Compare bit
			end
		end
	end

	always_ff @(posedge clock) begin
		if (!stall) begin
			aluData <= result;
		end
	end

	assign aluDone = aluToken.valid;

	//////////////////////////////////////////////////
	// Move path
	//////////////////////////////////////////////////

	assign predBit = predReg[command.src1[PRED_IDX_W-1:0]];

	always_ff @(posedge clock) begin
		if (reset) begin
			moveToken <= '0;
		end else begin
			moveToken <= '{valid: moveReq, dst: command.dst, issueNo: command.issueNo};
		end
	end

	always_ff @(posedge clock) begin
		// Decode only passes codes 1 and 2
		if (command.opCode == MOVE_PRED) begin
			moveData <= {{(DATA_W-1){1'b0}}, predBit};
		end else begin
			moveData <= command.data1;
		end
	end

	assign moveDone = moveToken.valid;

endmodule

`default_nettype wire

// File: rtl/scalarExecUnit.sv
/*
 * Scalar execution stage top
 * Decode, ALU with move path, even and odd load/store units
 */
`timescale 1ns/10ps
`default_nettype none

module scalarExecUnit
	import execPkg::*;
#(
	parameter int PRED_COUNT = 2
)(
	input  wire              clock,
	input  wire              reset,
	input  wire              stall,          // Freezes the ALU pipeline
	input  wire command_t    command,
	output memReq_t          memReq0,
	output memReq_t          memReq1,
	input  wire [1:0]        memReady,
	input  wire [1:0]        memGrant,
	input  wire [1:0]        endAccess,
	input  wire data_t       loadData0,
	input  wire data_t       loadData1,
	output wbToken_t         aluToken,
	output wbToken_t         moveToken,
	output wbToken_t         lsu0Token,
	output wbToken_t         lsu1Token,
	output data_t            aluData,
	output data_t            moveData,
	output data_t            lsu0Data,
	output data_t            lsu1Data,
	output logic             aluDone,
	output logic             moveDone,
	output logic             lsu0Done,
	output logic             lsu1Done,
	output logic             loadStall,
	output logic             storeStall
);

	logic       aluReq;
	logic       moveReq;
	logic [1:0] lsuReq;
	logic [1:0] unitLoadStall;
	logic [1:0] unitStoreStall;

	execDecode decodeUnit (
		.clock   (clock),
		.reset   (reset),
		.command (command),
		.aluReq  (aluReq),
		.moveReq (moveReq),
		.lsuReq  (lsuReq)
	);

	scalarAlu #(
		.PRED_COUNT (PRED_COUNT)
	) aluUnit (
		.clock     (clock),
		.reset     (reset),
		.stall     (stall),
		.aluReq    (aluReq),
		.moveReq   (moveReq),
		.command   (command),
		.aluToken  (aluToken),
		.aluData   (aluData),
		.aluDone   (aluDone),
		.moveToken (moveToken),
		.moveData  (moveData),
		.moveDone  (moveDone)
	);

	//////////////////////////////////////////////////
	// Load/store units
	//////////////////////////////////////////////////

	loadStoreUnit lsuEven (
		.clock      (clock),
		.reset      (reset),
		.lsuReq     (lsuReq[0]),
		.command    (command),
		.memReady   (memReady[0]),
		.memGrant   (memGrant[0]),
		.endAccess  (endAccess[0]),
		.loadData   (loadData0),
		.memReq     (memReq0),
		.wbToken    (lsu0Token),
		.wbData     (lsu0Data),
		.done       (lsu0Done),
		.loadStall  (unitLoadStall[0]),
		.storeStall (unitStoreStall[0])
	);

	loadStoreUnit lsuOdd (
		.clock      (clock),
		.reset      (reset),
		.lsuReq     (lsuReq[1]),
		.command    (command),
		.memReady   (memReady[1]),
		.memGrant   (memGrant[1]),
		.endAccess  (endAccess[1]),
		.loadData   (loadData1),
		.memReq     (memReq1),
		.wbToken    (lsu1Token),
		.wbData     (lsu1Data),
		.done       (lsu1Done),
		.loadStall  (unitLoadStall[1]),
		.storeStall (unitStoreStall[1])
	);

	// Either unit busy stalls the issuer
	assign loadStall  = |unitLoadStall;
	assign storeStall = |unitStoreStall;

endmodule

`default_nettype wire

// File: sim.f
rtl/execPkg.sv
rtl/execDecode.sv
rtl/scalarAlu.sv
rtl/loadStoreUnit.sv
rtl/scalarExecUnit.sv
testbench/tbMemory.sv
testbench/scalarExecUnit_assert.sv
testbench/scalarExecUnitTb.sv

// File: testbench/scalarExecUnitTb.sv
/*
 * Testbench of the scalar execution stage
 * Random commands, reference model of the ALU, move and load/store paths,
 * per-cycle checks, watchdog and final report
 */
`timescale 1ns/10ps
`default_nettype none

module scalarExecUnitTb
	import execPkg::*;
();

	localparam int NUM_COMMANDS = 400;
	localparam int MAX_CYCLES   = NUM_COMMANDS * 10;   // Worst case 10 cycles each

	typedef struct packed {
		logic     valid;
		regIdx_t  dst;
		issueNo_t issueNo;
		data_t    data;
	} expected_t;

	logic       clock = 1'b0;
	logic       reset = 1'b1;
	logic       stall = 1'b0;
	command_t   command = '0;
	memReq_t    memReq0;
	memReq_t    memReq1;
	logic [1:0] memReady;
	logic [1:0] memGrant;
	logic [1:0] endAccess;
	data_t      loadData0;
	data_t      loadData1;
	wbToken_t   aluToken;
	wbToken_t   moveToken;
	wbToken_t   lsuToken [2];
	data_t      aluData;
	data_t      moveData;
	data_t      lsuData [2];
	logic       aluDone;
	logic       moveDone;
	logic [1:0] lsuDone;
	logic       loadStall;
	logic       storeStall;

	// Reference model state
	command_t   aluStage;   // First ALU stage
	expected_t  aluExp;
	expected_t  moveExp;
	expected_t  lsuExp [2];
	memReq_t    reqExp [2];
	logic [1:0] lsuBusy;
	logic [1:0] lsuWrite;
	logic [7:0] lsuAddr [2];
	logic [1:0] endSeen;    // End of access in the previous cycle
	logic [1:0] pred;
	data_t      modelMem [256];

	integer seed       = 32'h218f0556;
	int     issued     = 0;
	int     droppedExp = 0;
	int     cycleCount = 0;
	int     checkCount = 0;
	int     errorCount = 0;

	always #5 clock = ~clock;

	scalarExecUnit #(.PRED_COUNT(2)) i_dut (
		.clock(clock), .reset(reset), .stall(stall), .command(command),
		.memReq0(memReq0), .memReq1(memReq1), .memReady(memReady),
		.memGrant(memGrant), .endAccess(endAccess),
		.loadData0(loadData0), .loadData1(loadData1),
		.aluToken(aluToken), .moveToken(moveToken),
		.lsu0Token(lsuToken[0]), .lsu1Token(lsuToken[1]),
		.aluData(aluData), .moveData(moveData), .lsu0Data(lsuData[0]), .lsu1Data(lsuData[1]),
		.aluDone(aluDone), .moveDone(moveDone), .lsu0Done(lsuDone[0]), .lsu1Done(lsuDone[1]),
		.loadStall(loadStall), .storeStall(storeStall)
	);

	tbMemory #(.SEED(32'h218f0556)) memory (
		.clock(clock), .reset(reset), .memReq0(memReq0), .memReq1(memReq1),
		.memReady(memReady), .memGrant(memGrant), .endAccess(endAccess),
		.loadData0(loadData0), .loadData1(loadData1)
	);

	bind scalarExecUnit scalarExecUnit_assert ruleChecks (
		.clock(clock), .reset(reset), .lsuReq(lsuReq),
		.unitLoadStall(unitLoadStall), .unitStoreStall(unitStoreStall),
		.memReq0(memReq0), .memReq1(memReq1), .memGrant(memGrant), .endAccess(endAccess)
	);

	//////////////////////////////////////////////////
	// Command rules and ALU operations
	//////////////////////////////////////////////////

	function automatic logic isAluCmd(input command_t c);
		return c.valid && (c.opType == ALU) && (c.opClass != MOVE_CLASS);
	endfunction

	function automatic logic isMoveCmd(input command_t c);
		return c.valid && (c.opType == ALU) && (c.opClass == MOVE_CLASS) &&
		       ((c.opCode == MOVE_PLAIN) || (c.opCode == MOVE_PRED));
	endfunction

	function automatic data_t aluResult(input command_t c);
		case (c.opCode)
			ADD:     return c.data1 + c.data2;
			SUB:     return c.data1 - c.data2;
			AND:     return c.data1 & c.data2;
			OR:      return c.data1 | c.data2;
			XOR:     return c.data1 ^ c.data2;
			SLL:     return c.data1 << c.data2[4:0];
			SRL:     return c.data1 >> c.data2[4:0];
			default: return ($signed(c.data1) < $signed(c.data2)) ? 32'd1 : 32'd0;
		endcase
	endfunction

	function automatic logic canIssue(input command_t c, input logic stalled);
		logic       unit;
		logic [7:0] addr;
		unit = c.opClass[0];
		addr = 8'(c.data1 + c.data2);
		if (c.opType == MEM) begin
			if (lsuBusy[unit]) begin
				return 1'b0;
			end
			// Same word in both units would race in the memory
			return !(lsuBusy[!unit] && (lsuAddr[!unit] == addr) &&
			         (lsuWrite[!unit] || c.opClass[1]));
		end
		return !(stalled && isAluCmd(c));
	endfunction

	task automatic makeCommand(output command_t c);
		int    kind;
		data_t target;
		kind      = $unsigned($random(seed)) % 16;
		c         = '0;
		c.valid   = 1'b1;
		c.dst     = regIdx_t'($random(seed));
		c.src1    = regIdx_t'($random(seed));
		c.issueNo = issueNo_t'(issued);
		c.opCode  = 3'($random(seed));
		c.data1   = $random(seed);
		c.data2   = $random(seed);
		c.data3   = $random(seed);
		if (kind < 7) begin
			c.opClass = opClass_t'($unsigned($random(seed)) % 3);
			if (kind < 2) begin
				c.opCode = CMPLT;   // Keeps predicates changing
			end
		end else if (kind < 10) begin
			c.opClass = MOVE_CLASS;
			if (kind < 9) begin
				c.opCode = (kind == 7) ? MOVE_PLAIN : MOVE_PRED;
			end
		end else if (kind < 15) begin
			c.opType  = MEM;
			c.opClass = opClass_t'($random(seed));
			target    = data_t'($unsigned($random(seed)) % 16);   // Small window, many hits
			c.data2   = target - c.data1;
		end else begin
			c.opType = ($random(seed) & 1) ? RSVD1 : RSVD2;
		end
	endtask

	//////////////////////////////////////////////////
	// Checks and model update
	//////////////////////////////////////////////////

	task automatic checkValue(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		checkCount++;
		assert (actual === expected) else begin
			errorCount++;
			$display("Error %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	task automatic checkFlag(input logic ok, input string what);
		checkCount++;
		assert (ok) else begin
			errorCount++;
			$display("%s", what);
		end
	endtask

	task automatic checkOutputs();
		checkValue("alu done", aluExp.valid, aluDone);
		checkValue("alu token valid", aluExp.valid, aluToken.valid);
		if (aluExp.valid) begin
			checkValue("alu token", {aluExp.dst, aluExp.issueNo}, {aluToken.dst, aluToken.issueNo});
			checkValue("alu data", aluExp.data, aluData);
		end
		checkValue("move done", moveExp.valid, moveDone);
		checkValue("move token valid", moveExp.valid, moveToken.valid);
		if (moveExp.valid) begin
			checkValue("move token", {moveExp.dst, moveExp.issueNo},
			           {moveToken.dst, moveToken.issueNo});
			checkValue("move data", moveExp.data, moveData);
		end
		for (int u = 0; u < 2; u++) begin
			memReq_t portReq;
			portReq = u ? memReq1 : memReq0;
			if (portReq.valid) begin
				checkFlag(lsuBusy[u], "Memory request from a load/store unit with nothing in flight");
				checkValue(u ? "lsu1 request" : "lsu0 request",
				           {reqExp[u].write, reqExp[u].address}, {portReq.write, portReq.address});
				if (reqExp[u].write) begin
					checkValue(u ? "lsu1 store data" : "lsu0 store data",
					           reqExp[u].writeData, portReq.writeData);
				end
			end
			checkValue(u ? "lsu1 done" : "lsu0 done", endSeen[u], lsuDone[u]);
			checkValue(u ? "lsu1 token valid" : "lsu0 token valid", endSeen[u],
			           lsuToken[u].valid);
			if (endSeen[u]) begin
				checkFlag(lsuBusy[u], "Load/store unit finished with no command in flight");
				checkValue(u ? "lsu1 token" : "lsu0 token", {lsuExp[u].dst, lsuExp[u].issueNo},
				           {lsuToken[u].dst, lsuToken[u].issueNo});
				checkValue(u ? "lsu1 data" : "lsu0 data", lsuExp[u].data, lsuData[u]);
			end
		end
		checkValue("load stall", |(lsuBusy & ~lsuWrite), loadStall);
		checkValue("store stall", |(lsuBusy & lsuWrite), storeStall);
	endtask

	task automatic updateModel(input command_t c, input logic stalled);
		logic       unit;
		logic [7:0] addr;
		unit = c.opClass[0];
		addr = 8'(c.data1 + c.data2);
		// Move sees predicates before this edge's compare
		moveExp.valid   = isMoveCmd(c);
		moveExp.dst     = c.dst;
		moveExp.issueNo = c.issueNo;
		moveExp.data    = (c.opCode == MOVE_PRED) ? data_t'(pred[c.src1[0]]) : c.data1;
		if (!stalled) begin
			aluExp.valid   = aluStage.valid;
			aluExp.dst     = aluStage.dst;
			aluExp.issueNo = aluStage.issueNo;
			aluExp.data    = aluResult(aluStage);
			if (aluStage.valid && (aluStage.opCode == CMPLT)) begin
				pred[aluStage.dst[0]] = aluExp.data[0];
			end
			aluStage       = c;
			aluStage.valid = isAluCmd(c);
		end
		if (c.valid && !isAluCmd(c) && !isMoveCmd(c) && (c.opType != MEM)) begin
			droppedExp++;   // Reserved type or unknown move code
		end
		lsuBusy &= ~endSeen;   // Finished units free up
		if (c.valid && (c.opType == MEM)) begin
			lsuBusy[unit]          = 1'b1;
			lsuWrite[unit]         = c.opClass[1];
			lsuAddr[unit]          = addr;
			reqExp[unit].write     = c.opClass[1];
			reqExp[unit].address   = c.data1 + c.data2;
			reqExp[unit].writeData = c.data3;
			lsuExp[unit].dst       = c.dst;
			lsuExp[unit].issueNo   = c.issueNo;
			lsuExp[unit].data      = c.opClass[1] ? '0 : modelMem[addr];
			if (c.opClass[1]) begin
				modelMem[addr] = c.data3;
			end
		end
		endSeen = endAccess;
	endtask

	always @(negedge clock) begin
		if (reset) begin
			checkValue("reset outputs", 8'b0, {aluDone, moveDone, lsuDone,
			           memReq0.valid, memReq1.valid, loadStall, storeStall});
			aluStage = '0;
			aluExp   = '0;
			moveExp  = '0;
			lsuBusy  = '0;
			endSeen  = '0;
			pred     = '0;
		end else begin
			checkOutputs();
			updateModel(command, stall);
		end
	end

	// Watchdog
	always @(posedge clock) begin
		cycleCount++;
		if (cycleCount >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles with commands still in flight", cycleCount);
			$display("Checks: %0d, errors: %0d", checkCount, errorCount);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	initial begin
		command_t nextCmd;
		for (int i = 0; i < 256; i++) begin
			modelMem[i] = (data_t'(i) * 32'h01030507) ^ 32'h5A0F0000;
		end
		repeat (8) @(posedge clock);
		#1;
		reset = 1'b0;
		while (issued < NUM_COMMANDS) begin
			@(posedge clock);
			#1;
			stall = ($unsigned($random(seed)) % 8) == 0;
			makeCommand(nextCmd);
			if (!canIssue(nextCmd, stall)) begin
				nextCmd.valid = 1'b0;   // Held off this cycle
			end
			command = nextCmd;
			if (nextCmd.valid) begin
				issued++;
			end
		end
		@(posedge clock);
		#1;
		command = '0;
		stall   = 1'b0;
		while (aluStage.valid || aluExp.valid || moveExp.valid || (lsuBusy != 2'b00)) begin
			@(posedge clock);
		end
		repeat (2) @(posedge clock);
		checkValue("dropped count", droppedExp, i_dut.decodeUnit.droppedCount);
		$display("Checks: %0d, errors: %0d, assertion failures: %0d",
		         checkCount, errorCount, i_dut.ruleChecks.failCount);
		if ((errorCount == 0) && (i_dut.ruleChecks.failCount == 0)) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: testbench/scalarExecUnit_assert.sv
/*
 * Protocol checks bound into the execution stage top
 * Issue to busy units, request hold until grant, end of access after grant
 */
`timescale 1ns/10ps
`default_nettype none

module scalarExecUnit_assert
	import execPkg::*;
(
	input wire          clock,
	input wire          reset,
	input wire [1:0]    lsuReq,
	input wire [1:0]    unitLoadStall,
	input wire [1:0]    unitStoreStall,
	input wire memReq_t memReq0,
	input wire memReq_t memReq1,
	input wire [1:0]    memGrant,
	input wire [1:0]    endAccess
);

	int         failCount = 0;   // Failed assertions so far
	logic [1:0] reqValid;
	logic [1:0] granted;         // Access granted and not yet ended

	assign reqValid = {memReq1.valid, memReq0.valid};

	always_ff @(posedge clock) begin
		if (reset) begin
			granted <= '0;
		end else begin
			granted <= (granted | (reqValid & memGrant)) & ~endAccess;
		end
	end

	issueToIdle: assert property (@(posedge clock) disable iff (reset)
		(lsuReq & (unitLoadStall | unitStoreStall)) == 2'b00)
		else begin
			$error("Load/store command issued to a busy unit");
			failCount++;
		end

	for (genvar i = 0; i < 2; i++) begin : perUnit
		requestHeld: assert property (@(posedge clock) disable iff (reset)
			(reqValid[i] && !memGrant[i]) |=> reqValid[i])
			else begin
				$error("Memory request %0d dropped before its grant", i);
				failCount++;
			end

		endAfterGrant: assert property (@(posedge clock) disable iff (reset)
			endAccess[i] |-> granted[i])
			else begin
				$error("End of access on port %0d without a granted request", i);
				failCount++;
			end
	end

endmodule

`default_nettype wire

// File: testbench/tbMemory.sv
/*
 * Two-port memory model
 * Random port readiness, grant delay of 0 to 3 cycles,
 * access time of 1 to 4 cycles, 256-word array with an address-dependent fill
 */
`timescale 1ns/10ps
`default_nettype none

module tbMemory
	import execPkg::*;
#(
	parameter int SEED = 1
)(
	input  wire          clock,
	input  wire          reset,
	input  wire memReq_t memReq0,
	input  wire memReq_t memReq1,
	output logic [1:0]   memReady,
	output logic [1:0]   memGrant,
	output logic [1:0]   endAccess,
	output data_t        loadData0,
	output data_t        loadData1
);

	typedef enum logic [1:0] {FREE, WAITING, BUSY} portPhase_e;

	data_t      mem [256];
	memReq_t    req [2];
	memReq_t    held [2];       // Access taken at grant
	portPhase_e phase [2];
	int         count [2];
	data_t      readWord [2];
	logic [1:0] readyDraw;      // Random readiness while free
	integer     seed;

	assign req[0]    = memReq0;
	assign req[1]    = memReq1;
	assign loadData0 = readWord[0];
	assign loadData1 = readWord[1];

	// Ready only drops while no request is taken
	assign memReady[0] = readyDraw[0] || (phase[0] != FREE);
	assign memReady[1] = readyDraw[1] || (phase[1] != FREE);

	initial begin
		seed        = SEED;
		memGrant    = '0;
		endAccess   = '0;
		readyDraw   = '1;
		readWord[0] = '0;
		readWord[1] = '0;
		for (int i = 0; i < 256; i++) begin
			mem[i] = (data_t'(i) * 32'h01030507) ^ 32'h5A0F0000;
		end
	end

	always @(posedge clock) begin
		int   waitCycles;
		logic grantNow;
		for (int p = 0; p < 2; p++) begin
			readyDraw[p] <= ($unsigned($random(seed)) % 4) != 0;
			memGrant[p]  <= 1'b0;
			endAccess[p] <= 1'b0;
			grantNow     = 1'b0;
			if (reset) begin
				phase[p] <= FREE;
			end else begin
				case (phase[p])
					FREE: begin
						if (req[p].valid) begin
							waitCycles = $unsigned($random(seed)) % 4;
							grantNow   = (waitCycles == 0);
							count[p]   <= waitCycles - 1;
							phase[p]   <= WAITING;
						end
					end
					WAITING: begin
						grantNow = (count[p] == 0);
						count[p] <= count[p] - 1;
					end
					default: begin
						if (count[p] == 0) begin
							endAccess[p] <= 1'b1;
							phase[p]     <= FREE;
							if (held[p].write) begin
								mem[held[p].address[7:0]] <= held[p].writeData;
							end else begin
								readWord[p] <= mem[held[p].address[7:0]];
							end
						end else begin
							count[p] <= count[p] - 1;
						end
					end
				endcase
				// Later assignments override the waiting setup above
				if (grantNow) begin
					memGrant[p] <= 1'b1;
					held[p]     <= req[p];
					phase[p]    <= BUSY;
					count[p]    <= $unsigned($random(seed)) % 4;
				end
			end
		end
	end

endmodule

`default_nettype wire
